/* hdl/soc_pkg.sv */
`default_nettype none

package soc_pkg;

    // Data path width
    localparam int xlen = 64;

    // Data RAM window, 8 KB of doublewords
    localparam logic [xlen-1:0] ram_base = 64'h0000_0000_0000_1000;
    localparam logic [xlen-1:0] ram_size = 64'h0000_0000_0000_2000;
    localparam int ram_words = 1024;
    localparam int ram_addr_width = 10;

    // Memory mapped I/O registers
    localparam logic [xlen-1:0] console_addr = 64'h0000_0000_8000_0000;
    localparam logic [xlen-1:0] key_echo_addr = 64'h0000_0000_8000_0008;

    // RV64I major opcodes for the supported subset
    localparam logic [6:0] rv_lui = 7'b0110111;
    localparam logic [6:0] rv_op_imm = 7'b0010011;
    localparam logic [6:0] rv_op = 7'b0110011;
    localparam logic [6:0] rv_load = 7'b0000011;
    localparam logic [6:0] rv_store = 7'b0100011;

    // funct3 values: add/addi share one, ld/sd the other
    localparam logic [2:0] f3_add = 3'b000;
    localparam logic [2:0] f3_double = 3'b011;

    // Decoded operations, anything unsupported lands on op_nop
    typedef enum logic [2:0] {
        op_lui,
        op_addi,
        op_add,
        op_ld,
        op_sd,
        op_nop
    } opcode_t;

    // Core sequencing states
    typedef enum logic [1:0] {
        st_fetch,
        st_execute,
        st_mem_wait,
        st_irq
    } cpu_state_t;

endpackage

`default_nettype wire

/* hdl/interrupt_controller.sv */
`timescale 1ns/1ps
`default_nettype none

module interrupt_controller (
    input  logic       clk,
    input  logic       reset,
    input  logic       key_strobe,
    input  logic [7:0] key_code,
    input  logic       irq_ack,
    output logic       irq_pending,
    output logic [7:0] irq_code
);
    logic accept;

    // One level only, new keys dropped while one is pending
    assign accept = key_strobe && !irq_pending;

    always_ff @(posedge clk or negedge reset) begin
        if (!reset)
            irq_pending <= 1'b0;
        else if (irq_ack)
            irq_pending <= 1'b0;
        else if (accept)
            irq_pending <= 1'b1;
    end

    // Key code held until the core echoes it
    always_ff @(posedge clk) begin
        if (accept)
            irq_code <= key_code;
    end

    // Core must only ack a live request
    a_ack_needs_pending: assert property (@(posedge clk) disable iff (!reset)
        irq_ack |-> irq_pending);

endmodule

`default_nettype wire

/* hdl/data_ram.sv */
`timescale 1ns/1ps
`default_nettype none

module data_ram (
    input  logic                               clk,
    input  logic                               ram_write,
    input  logic                               ram_read,
    input  logic [soc_pkg::ram_addr_width-1:0] ram_index,
    input  logic [soc_pkg::xlen-1:0]           ram_write_data,
    output logic [soc_pkg::xlen-1:0]           ram_read_data
);
    import soc_pkg::*;

    logic [xlen-1:0] mem [ram_words];

    // Single port, registered read, maps to block RAM
    always_ff @(posedge clk) begin
        if (ram_write)
            mem[ram_index] <= ram_write_data;
        if (ram_read)
            ram_read_data <= mem[ram_index];
    end

endmodule

`default_nettype wire

/* hdl/bus_decoder.sv */
`timescale 1ns/1ps
`default_nettype none

module bus_decoder (
    input  logic                               clk,
    input  logic                               reset,
    input  logic [soc_pkg::xlen-1:0]           bus_address,
    input  logic [soc_pkg::xlen-1:0]           bus_write_data,
    input  logic                               bus_write,
    input  logic                               bus_read,
    output logic [soc_pkg::xlen-1:0]           bus_read_data,
    output logic                               ram_write,
    output logic                               ram_read,
    output logic [soc_pkg::ram_addr_width-1:0] ram_index,
    output logic [soc_pkg::xlen-1:0]           ram_write_data,
    input  logic [soc_pkg::xlen-1:0]           ram_read_data,
    output logic                               io_write,
    output logic [soc_pkg::xlen-1:0]           io_address,
    output logic [soc_pkg::xlen-1:0]           io_data
);
    import soc_pkg::*;

    logic ram_hit;
    logic io_hit;
    logic read_from_ram;
    logic [xlen-1:0] ram_offset;

    // Region select
    assign ram_hit = (bus_address >= ram_base) && (bus_address < ram_base + ram_size);
    assign io_hit = (bus_address == console_addr) || (bus_address == key_echo_addr);

    // Doubleword index inside the RAM window
    assign ram_offset = bus_address - ram_base;
    assign ram_index = ram_offset[ram_addr_width+2:3];
    assign ram_write_data = bus_write_data;
    assign ram_write = bus_write && ram_hit;
    assign ram_read = bus_read && ram_hit;

    // I/O writes leave in the same cycle
    assign io_write = bus_write && io_hit;
    assign io_address = bus_address;
    assign io_data = bus_write_data;

    // Track where the pending read went
    always_ff @(posedge clk or negedge reset) begin
        if (!reset)
            read_from_ram <= 1'b0;
        else if (bus_read)
            read_from_ram <= ram_hit;
    end

    // Unmapped and I/O loads read zero
    assign bus_read_data = read_from_ram ? ram_read_data : '0;

endmodule

`default_nettype wire

/* hdl/execute_unit.sv */
`timescale 1ns/1ps
`default_nettype none

module execute_unit (
    input  soc_pkg::opcode_t         opcode,
    input  logic [31:0]              instr,
    input  logic [soc_pkg::xlen-1:0] rs1_data,
    input  logic [soc_pkg::xlen-1:0] rs2_data,
    output logic [soc_pkg::xlen-1:0] result
);
    import soc_pkg::*;

    logic [xlen-1:0] imm_u;
    logic [xlen-1:0] imm_i;
    logic [xlen-1:0] imm_s;
    logic [xlen-1:0] imm;

    // U type, upper 20 bits then sign extension from bit 31
    assign imm_u = {{(xlen-32){instr[31]}}, instr[31:12], 12'b0};
    // I type for addi and ld
    assign imm_i = {{(xlen-12){instr[31]}}, instr[31:20]};
    // S type is split around rd
    assign imm_s = {{(xlen-12){instr[31]}}, instr[31:25], instr[11:7]};

    // Immediate select
    always_comb begin
        case (opcode)
            op_lui: imm = imm_u;
            op_sd: imm = imm_s;
            default: imm = imm_i;
        endcase
    end

    // Single adder serves ALU ops and address generation
    always_comb begin
        case (opcode)
            op_lui: result = imm;
            op_add: result = rs1_data + rs2_data;
            default: result = rs1_data + imm;
        endcase
    end

    // Known opcode must give a known value, catching X from the regfile
    always_comb begin
        if (!$isunknown(opcode))
            a_result_known: assert final (!$isunknown(result));
    end

endmodule

`default_nettype wire

/* hdl/register_file.sv */
`timescale 1ns/1ps
`default_nettype none

module register_file (
    input  logic                     clk,
    input  logic                     reset,
    input  logic [4:0]               rs1_index,
    input  logic [4:0]               rs2_index,
    output logic [soc_pkg::xlen-1:0] rs1_data,
    output logic [soc_pkg::xlen-1:0] rs2_data,
    input  logic                     rd_write,
    input  logic [4:0]               rd_index,
    input  logic [soc_pkg::xlen-1:0] rd_data
);
    import soc_pkg::*;

    logic [xlen-1:0] regs [32];

    // Architectural state starts at zero
    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            for (int i = 0; i < 32; i++)
                regs[i] <= '0;
        end else if (rd_write && rd_index != 5'd0) begin
            // x0 writes dropped
            regs[rd_index] <= rd_data;
        end
    end

    // Combinational reads, x0 forced to zero
    assign rs1_data = (rs1_index == 5'd0) ? '0 : regs[rs1_index];
    assign rs2_data = (rs2_index == 5'd0) ? '0 : regs[rs2_index];

endmodule

`default_nettype wire

/* hdl/cpu_control.sv */
`timescale 1ns/1ps
`default_nettype none

module cpu_control (
    input  logic                     clk,
    input  logic                     reset,
    input  logic [31:0]              instruction,
    output logic [31:0]              pc,
    output soc_pkg::opcode_t         opcode,
    output logic [31:0]              instr,
    output logic [4:0]               rs1_index,
    output logic [4:0]               rs2_index,
    output logic [4:0]               rd_index,
    output logic                     rd_write,
    output logic [soc_pkg::xlen-1:0] rd_data,
    input  logic [soc_pkg::xlen-1:0] rs2_data,
    input  logic [soc_pkg::xlen-1:0] result,
    output logic [soc_pkg::xlen-1:0] bus_address,
    output logic [soc_pkg::xlen-1:0] bus_write_data,
    output logic                     bus_write,
    output logic                     bus_read,
    input  logic [soc_pkg::xlen-1:0] bus_read_data,
    input  logic                     irq_pending,
    input  logic [7:0]               irq_code,
    output logic                     irq_ack
);
    import soc_pkg::*;

    cpu_state_t state;
    cpu_state_t state_next;
    logic [6:0] major;
    logic [2:0] funct3;
    logic [6:0] funct7;

    // Instruction fields
    assign major = instr[6:0];
    assign funct3 = instr[14:12];
    assign funct7 = instr[31:25];
    assign rd_index = instr[11:7];
    assign rs1_index = instr[19:15];
    assign rs2_index = instr[24:20];

    // Decode into the small opcode set
    always_comb begin
        opcode = op_nop;
        case (major)
            rv_lui: opcode = op_lui;
            rv_op_imm: begin
                if (funct3 == f3_add)
                    opcode = op_addi;
            end
            rv_op: begin
                // Only plain ADD, SUB and friends fall through to nop
                if (funct3 == f3_add && funct7 == 7'b0)
                    opcode = op_add;
            end
            rv_load: begin
                if (funct3 == f3_double)
                    opcode = op_ld;
            end
            rv_store: begin
                if (funct3 == f3_double)
                    opcode = op_sd;
            end
            default: opcode = op_nop;
        endcase
    end

    // State, pc and instruction register
    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            state <= st_fetch;
            pc <= '0;
            instr <= '0;
        end else begin
            state <= state_next;
            // Skip the capture when an interrupt preempts this fetch
            if (state == st_fetch && !irq_pending)
                instr <= instruction;
            if (state == st_execute)
                pc <= pc + 32'd4;
        end
    end

    // Next state and per-state strobes
    always_comb begin
        state_next = state;
        rd_write = 1'b0;
        rd_data = result;
        bus_address = result;
        bus_write_data = rs2_data;
        bus_write = 1'b0;
        bus_read = 1'b0;
        irq_ack = 1'b0;
        case (state)
            st_fetch: begin
                state_next = irq_pending ? st_irq : st_execute;
            end
            st_execute: begin
                state_next = st_fetch;
                case (opcode)
                    op_lui, op_addi, op_add: rd_write = 1'b1;
                    op_sd: bus_write = 1'b1;
                    op_ld: begin
                        bus_read = 1'b1;
                        state_next = st_mem_wait;
                    end
                    default: rd_write = 1'b0;
                endcase
            end
            st_mem_wait: begin
                // RAM data arrives one cycle after the read strobe
                rd_write = 1'b1;
                rd_data = bus_read_data;
                state_next = st_fetch;
            end
            st_irq: begin
                // Echo the key code, then release the controller
                bus_address = key_echo_addr;
                bus_write_data = {{(xlen-8){1'b0}}, irq_code};
                bus_write = 1'b1;
                irq_ack = 1'b1;
                state_next = st_fetch;
            end
            default: state_next = st_fetch;
        endcase
    end

    // One bus request at a time
    a_bus_exclusive: assert property (@(posedge clk) disable iff (!reset)
        !(bus_write && bus_read));

    // Ack only from st_irq, and fetch resumes right after
    a_ack_in_irq: assert property (@(posedge clk) disable iff (!reset)
        irq_ack |-> (state == st_irq) ##1 (state == st_fetch));

endmodule

`default_nettype wire

/* hdl/soc_top.sv */
`timescale 1ns/1ps
`default_nettype none

module soc_top (
    input  logic                     clk,
    input  logic                     reset,
    output logic [31:0]              pc,
    input  logic [31:0]              instruction,
    input  logic                     key_strobe,
    input  logic [7:0]               key_code,
    output logic                     io_write,
    output logic [soc_pkg::xlen-1:0] io_address,
    output logic [soc_pkg::xlen-1:0] io_data
);
    import soc_pkg::*;

    // Core to datapath
    opcode_t opcode;
    logic [31:0] instr;
    logic [4:0] rs1_index;
    logic [4:0] rs2_index;
    logic [4:0] rd_index;
    logic rd_write;
    logic [xlen-1:0] rd_data;
    logic [xlen-1:0] rs1_data;
    logic [xlen-1:0] rs2_data;
    logic [xlen-1:0] result;

    // Core data bus
    logic [xlen-1:0] bus_address;
    logic [xlen-1:0] bus_write_data;
    logic bus_write;
    logic bus_read;
    logic [xlen-1:0] bus_read_data;

    // RAM port
    logic ram_write;
    logic ram_read;
    logic [ram_addr_width-1:0] ram_index;
    logic [xlen-1:0] ram_write_data;
    logic [xlen-1:0] ram_read_data;

    // Interrupt handshake
    logic irq_pending;
    logic [7:0] irq_code;
    logic irq_ack;

    cpu_control cpu_control_inst (
        .clk(clk), .reset(reset), .instruction(instruction), .pc(pc),
        .opcode(opcode), .instr(instr), .rs1_index(rs1_index),
        .rs2_index(rs2_index), .rd_index(rd_index), .rd_write(rd_write),
        .rd_data(rd_data), .rs2_data(rs2_data), .result(result),
        .bus_address(bus_address), .bus_write_data(bus_write_data),
        .bus_write(bus_write), .bus_read(bus_read), .bus_read_data(bus_read_data),
        .irq_pending(irq_pending), .irq_code(irq_code), .irq_ack(irq_ack)
    );

    register_file register_file_inst (
        .clk(clk), .reset(reset), .rs1_index(rs1_index), .rs2_index(rs2_index),
        .rs1_data(rs1_data), .rs2_data(rs2_data), .rd_write(rd_write),
        .rd_index(rd_index), .rd_data(rd_data)
    );

    execute_unit execute_unit_inst (
        .opcode(opcode), .instr(instr), .rs1_data(rs1_data),
        .rs2_data(rs2_data), .result(result)
    );

    bus_decoder bus_decoder_inst (
        .clk(clk), .reset(reset), .bus_address(bus_address),
        .bus_write_data(bus_write_data), .bus_write(bus_write), .bus_read(bus_read),
        .bus_read_data(bus_read_data), .ram_write(ram_write), .ram_read(ram_read),
        .ram_index(ram_index), .ram_write_data(ram_write_data),
        .ram_read_data(ram_read_data), .io_write(io_write),
        .io_address(io_address), .io_data(io_data)
    );

    data_ram data_ram_inst (
        .clk(clk), .ram_write(ram_write), .ram_read(ram_read),
        .ram_index(ram_index), .ram_write_data(ram_write_data),
        .ram_read_data(ram_read_data)
    );

    interrupt_controller interrupt_controller_inst (
        .clk(clk), .reset(reset), .key_strobe(key_strobe), .key_code(key_code),
        .irq_ack(irq_ack), .irq_pending(irq_pending), .irq_code(irq_code)
    );

endmodule

`default_nettype wire

/* tb/soc_tb_model.svh */
`ifndef SOC_TB_MODEL_SVH
`define SOC_TB_MODEL_SVH

// Reference architectural state
logic [xlen-1:0] model_regs [32];
logic [xlen-1:0] model_ram [logic [xlen-1:0]];
int written_slots [$];

// Uniform value in 0..n-1
function automatic int pick(input int n);
    return $unsigned($random(seed)) % n;
endfunction

// Destination register, never the base pointers x1 and x2
function automatic logic [4:0] pick_dest();
    int r;
    r = pick(30);
    return (r == 0) ? 5'd0 : 5'(r + 2);
endfunction

// I type layout, also used by ld
function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [4:0] rs1,
                                      input logic [2:0] f3, input logic [4:0] rd,
                                      input logic [6:0] op);
    return {imm, rs1, f3, rd, op};
endfunction

// sd with the immediate split around the rd field
function automatic logic [31:0] enc_sd(input logic [11:0] imm, input logic [4:0] rs2,
                                       input logic [4:0] rs1);
    return {imm[11:5], rs2, rs1, 3'b011, imm[4:0], 7'b0100011};
endfunction

function automatic logic [xlen-1:0] model_load(input logic [xlen-1:0] a);
    // Only the RAM window returns data
    if (a >= ram_base && a < ram_base + ram_size && model_ram.exists({a[xlen-1:3], 3'b0}))
        return model_ram[{a[xlen-1:3], 3'b0}];
    return '0;
endfunction

function automatic void model_store(input logic [xlen-1:0] a, input logic [xlen-1:0] d);
    if (a >= ram_base && a < ram_base + ram_size) begin
        model_ram[{a[xlen-1:3], 3'b0}] = d;
    end else if (a == console_addr) begin
        expect_addr.push_back(a);
        expect_data.push_back(d);
    end
endfunction

// One instruction at architectural level
function automatic void model_step(input logic [31:0] w);
    logic [xlen-1:0] rs1;
    logic [xlen-1:0] v;
    logic wr;
    rs1 = model_regs[w[19:15]];
    v = '0;
    wr = 1'b0;
    case (w[6:0])
        7'b0110111: begin
            v = {{32{w[31]}}, w[31:12], 12'b0};
            wr = 1'b1;
        end
        7'b0010011: begin
            v = rs1 + {{52{w[31]}}, w[31:20]};
            wr = (w[14:12] == 3'b000);
        end
        7'b0110011: begin
            v = rs1 + model_regs[w[24:20]];
            wr = (w[14:12] == 3'b000) && (w[31:25] == 7'b0);
        end
        7'b0000011: begin
            v = model_load(rs1 + {{52{w[31]}}, w[31:20]});
            wr = (w[14:12] == 3'b011);
        end
        7'b0100011: begin
            if (w[14:12] == 3'b011)
                model_store(rs1 + {{52{w[31]}}, w[31:25], w[11:7]}, model_regs[w[24:20]]);
        end
        default: wr = 1'b0;
    endcase
    // x0 stays zero
    if (wr && w[11:7] != 5'd0)
        model_regs[w[11:7]] = v;
endfunction

// Random program, run through the model while it is built
task automatic gen_program();
    logic [31:0] w;
    logic [11:0] off;
    int kind;
    int slot;
    for (int i = 0; i < 256; i++)
        prog[i] = nop_word;
    for (int i = 0; i < 32; i++)
        model_regs[i] = '0;
    // x1 at the RAM base, x2 doubled up to the console address
    prog[0] = {20'h00001, 5'd1, 7'b0110111};
    prog[1] = {20'h40000, 5'd2, 7'b0110111};
    prog[2] = {7'b0, 5'd2, 5'd2, 3'b000, 5'd2, 7'b0110011};
    for (int i = 0; i < prog_len; i++) begin
        if (i >= setup_count) begin
            kind = pick(16);
            if (kind < 3) begin
                w = {20'(pick(1 << 20)), pick_dest(), 7'b0110111};
            end else if (kind < 6) begin
                w = enc_i(12'(pick(4096)), 5'(pick(32)), 3'b000, pick_dest(), 7'b0010011);
            end else if (kind < 9) begin
                w = {7'b0, 5'(pick(32)), 5'(pick(32)), 3'b000, pick_dest(), 7'b0110011};
            end else if (kind < 11) begin
                // Reload a stored slot, or probe just below the RAM window
                if (written_slots.size() > 0 && pick(4) != 0)
                    off = 12'(written_slots[pick(written_slots.size())] * 8);
                else
                    off = 12'hff8;
                w = enc_i(off, 5'd1, 3'b011, pick_dest(), 7'b0000011);
            end else if (kind < 15) begin
                slot = pick(5);
                if (slot < 2) begin
                    w = enc_sd(12'd0, 5'(pick(32)), 5'd2);
                end else if (slot < 4) begin
                    slot = pick(16);
                    written_slots.push_back(slot);
                    w = enc_sd(12'(slot * 8), 5'(pick(32)), 5'd1);
                end else begin
                    // Unmapped store, dropped by the decoder
                    w = enc_sd(12'hff0, 5'(pick(32)), 5'd1);
                end
            end else begin
                // Custom-0 major opcode, outside the supported set
                w = $random(seed);
                w[6:0] = 7'b0001011;
            end
            prog[i] = w;
        end
        model_step(prog[i]);
    end
endtask

`endif

/* tb/soc_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module soc_tb;
    import soc_pkg::*;

    localparam int random_count = 200;
    localparam int setup_count = 3;
    localparam int prog_len = setup_count + random_count;
    localparam int key_count = 10;
    // Worst case 3 cycles per instruction, irq service per key, plus reset and drain
    localparam int timeout_cycles = random_count * 3 + key_count * 4 + 150;
    localparam logic [31:0] nop_word = 32'h0000_0013;

    logic clk;
    logic reset;
    logic [31:0] pc;
    logic [31:0] instruction;
    logic key_strobe;
    logic [7:0] key_code;
    logic io_write;
    logic [xlen-1:0] io_address;
    logic [xlen-1:0] io_data;

    integer seed = 15854;
    logic [31:0] prog [256];
    logic [xlen-1:0] expect_addr [$];
    logic [xlen-1:0] expect_data [$];
    int expect_index = 0;
    logic [7:0] sent_code;
    int keys_sent;
    int keys_echoed = 0;
    int cycles = 0;
    logic [31:0] last_pc = '0;

    `include "soc_tb_model.svh"

    soc_top soc_top_inst (
        .clk(clk), .reset(reset), .pc(pc), .instruction(instruction),
        .key_strobe(key_strobe), .key_code(key_code), .io_write(io_write),
        .io_address(io_address), .io_data(io_data)
    );

    initial clk = 1'b0;
    always #4 clk = ~clk;

    // Instruction port, no-op slide past the program
    assign instruction = (pc < 32'd1024) ? prog[pc[9:2]] : nop_word;

    task automatic stop_run();
        $display("Simulation failed");
        $fatal(1, "run stopped at first failure");
    endtask

    task automatic check_io_write(input string name, input logic [xlen-1:0] exp_addr,
                                  input logic [xlen-1:0] exp_data,
                                  input logic [xlen-1:0] act_addr,
                                  input logic [xlen-1:0] act_data);
        if (act_addr !== exp_addr || act_data !== exp_data) begin
            $display("ERROR %s: expected %h data %h, actual %h data %h",
                     name, exp_addr, exp_data, act_addr, act_data);
            stop_run();
        end
    endtask

    task automatic check_key_echo(input string name, input logic [7:0] exp_code,
                                  input logic [7:0] act_code);
        if (act_code !== exp_code) begin
            $display("ERROR %s: expected %h, actual %h", name, exp_code, act_code);
            stop_run();
        end
    endtask

    task automatic check_pc(input string name, input logic [31:0] exp_pc,
                            input logic [31:0] act_pc);
        if (act_pc !== exp_pc) begin
            $display("ERROR %s: expected %h, actual %h", name, exp_pc, act_pc);
            stop_run();
        end
    endtask

    // Each key waits for the echo of the one before
    task automatic send_keys();
        for (int k = 0; k < key_count; k++) begin
            repeat (4 + pick(24)) @(negedge clk);
            sent_code = 8'(pick(256));
            keys_sent = keys_sent + 1;
            key_strobe = 1'b1;
            key_code = sent_code;
            @(negedge clk);
            key_strobe = 1'b0;
            while (keys_echoed != keys_sent)
                @(negedge clk);
        end
    endtask

    initial begin
        reset = 1'b0;
        key_strobe = 1'b0;
        key_code = '0;
        sent_code = '0;
        keys_sent = 0;
        gen_program();
        repeat (8) @(posedge clk);
        @(negedge clk);
        reset = 1'b1;
        send_keys();
        while (pc < 32'(prog_len * 4) || expect_index < expect_data.size())
            @(negedge clk);
        // Drain, catching any stray write
        repeat (10) @(negedge clk);
        if (expect_index == expect_data.size() && keys_echoed == key_count) begin
            $display("Simulation passed");
            $finish;
        end else begin
            $display("%0d of %0d console writes seen, %0d of %0d keys echoed",
                     expect_index, expect_data.size(), keys_echoed, key_count);
            stop_run();
        end
    end

    // Bus monitor, mid-cycle sampling
    always @(negedge clk) begin
        if (!reset) begin
            if (io_write) begin
                $display("io_write went high while reset was asserted");
                stop_run();
            end
            check_pc("reset pc", 32'd0, pc);
        end else begin
            // Fetch order, one word forward per instruction
            if (pc != last_pc) begin
                check_pc("pc step", last_pc + 32'd4, pc);
                last_pc = pc;
            end
            if (io_write && io_address == key_echo_addr) begin
                if (keys_echoed >= keys_sent) begin
                    $display("key echo written with no key strobe outstanding");
                    stop_run();
                end
                check_key_echo("key echo", sent_code, io_data[7:0]);
                check_io_write("key echo", key_echo_addr, {56'b0, sent_code},
                               io_address, io_data);
                keys_echoed = keys_echoed + 1;
            end else if (io_write) begin
                if (expect_index >= expect_data.size()) begin
                    $display("console write at %h not produced by the model", io_address);
                    stop_run();
                end
                check_io_write("console store", expect_addr[expect_index],
                               expect_data[expect_index], io_address, io_data);
                expect_index = expect_index + 1;
            end
        end
    end

    // Hang guard
    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles >= timeout_cycles) begin
            $display("timeout after %0d cycles, program or key echo stalled", cycles);
            stop_run();
        end
    end

endmodule

`default_nettype wire

/* all.f */
+incdir+tb
hdl/soc_pkg.sv
hdl/interrupt_controller.sv
hdl/data_ram.sv
hdl/bus_decoder.sv
hdl/execute_unit.sv
hdl/register_file.sv
hdl/cpu_control.sv
hdl/soc_top.sv
tb/soc_tb.sv

/* Makefile */
VERILATOR ?= verilator
TOP ?= soc_tb
FILELIST ?= all.f
BUILD_DIR ?= obj_dir
LOG ?= sim.log
VFLAGS ?= --binary --timing --assert

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "^Simulation passed$$" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
